//--- dsp_handler.f
src/dsp_xintf_pkg.sv
src/tx_sequencer.sv
src/tx_word_select.sv
src/rx_sequencer.sv
src/rx_param_bank.sv
src/dsp_handler.sv
testbench/tb_clock_gen.sv
testbench/tb_dpbram_model.sv
testbench/tb_dsp_handler_assert.sv
testbench/tb_dsp_handler.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_dsp_handler
FILELIST  := dsp_handler.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_dsp_handler.sv
`timescale 1ns/1ps

module tb_dsp_handler;

	localparam int AW = dsp_xintf_pkg::ADDR_W;
	localparam int WW = dsp_xintf_pkg::WORD_W;
	localparam int PW = dsp_xintf_pkg::PARAM_W;
	localparam int TXN = dsp_xintf_pkg::TX_WORDS;
	localparam int RXN = dsp_xintf_pkg::RX_WORDS;
	localparam int BASE = dsp_xintf_pkg::RX_BASE;
	localparam int LIMIT = 2000;

	logic i_clk, i_rst, i_w_ready, i_r_valid;
	logic o_w_valid, o_xintf_w_ram_ce, o_xintf_r_ram_ce, o_rx_done;
	logic [AW-1:0] o_xintf_w_ram_addr, o_xintf_r_ram_addr;
	logic [WW-1:0] o_xintf_w_ram_din, i_xintf_r_ram_dout, i_set_mode, i_set_cmd;
	logic [WW-1:0] o_dsp_status, o_dsp_cmd, o_dsp_ver;
	logic [PW-1:0] i_max_duty, i_max_phase, i_set_c, i_set_v, i_c_adc, i_v_adc;
	logic [PW-1:0] o_dsp_max_duty, o_dsp_max_phase, o_dsp_set_c, o_dsp_set_v;
	logic [WW-1:0] rx_words [0:RXN-1];
	int checks = 0;
	int errors = 0;
	int frames = 0;
	bit timed_out = 1'b0;

	tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(2)) u_clk (.o_clk(i_clk), .o_rst(i_rst));

	dsp_handler DUT (.*);

	tb_dpbram_model u_ram (
		.i_clk    (i_clk),
		.i_w_ce   (o_xintf_w_ram_ce),
		.i_w_addr (o_xintf_w_ram_addr),
		.i_w_din  (o_xintf_w_ram_din),
		.i_r_ce   (o_xintf_r_ram_ce),
		.i_r_addr (o_xintf_r_ram_addr),
		.o_r_dout (i_xintf_r_ram_dout)
	);

	bind dsp_handler tb_dsp_handler_assert u_assert (.*);

	// mode and cmd lead the frame and six 32-bit fields follow low half first
	function automatic logic [WW-1:0] tx_expected_word(input int slot);
		logic [PW-1:0] field;
		case ((slot - 2) / 2)
			0: field = i_max_duty;
			1: field = i_max_phase;
			2: field = i_set_c;
			3: field = i_set_v;
			4: field = i_c_adc;
			default: field = i_v_adc;
		endcase
		if (slot == 0) return i_set_mode;
		if (slot == 1) return i_set_cmd;
		return (slot % 2 == 1) ? field[PW-1:WW] : field[WW-1:0];
	endfunction

	// fields 0..3 are 32-bit pairs and 4..6 are status, cmd and version
	function automatic logic [PW-1:0] rx_expected(input int field);
		if (field < 4) return {rx_words[2 * field + 1], rx_words[2 * field]};
		return {{(PW - WW){1'b0}}, rx_words[field + 4]};
	endfunction

	function automatic logic [PW-1:0] rx_actual(input int field);
		case (field)
			0: return o_dsp_max_duty;
			1: return o_dsp_max_phase;
			2: return o_dsp_set_c;
			3: return o_dsp_set_v;
			4: return {{(PW - WW){1'b0}}, o_dsp_status};
			5: return {{(PW - WW){1'b0}}, o_dsp_cmd};
			default: return {{(PW - WW){1'b0}}, o_dsp_ver};
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [PW-1:0] exp,
		input logic [PW-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic end_run();
		$display("checks %0d, errors %0d, transmit frames %0d", checks, errors, frames);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		errors++;
		timed_out = 1'b1;
	endtask

	task automatic randomize_fields();
		i_set_mode = WW'($urandom());
		i_set_cmd = WW'($urandom());
		i_max_duty = $urandom();
		i_max_phase = $urandom();
		i_set_c = $urandom();
		i_set_v = $urandom();
		i_c_adc = $urandom();
		i_v_adc = $urandom();
	endtask

	task automatic check_quiet(input string name);
		compare_value({name, " control"}, '0,
			PW'({o_xintf_w_ram_ce, o_xintf_r_ram_ce, o_w_valid, o_rx_done}));
		for (int f = 0; f < 7; f++) begin
			compare_value($sformatf("%s field %0d", name, f), '0, rx_actual(f));
		end
	endtask

	task automatic idle_rx_window(input string name, input int cycles);
		repeat (cycles) begin
			@(negedge i_clk);
			compare_value({name, " read ce"}, '0, PW'(o_xintf_r_ram_ce));
			for (int f = 0; f < 7; f++) begin
				compare_value($sformatf("%s field %0d", name, f), rx_expected(f), rx_actual(f));
			end
		end
	endtask

	task automatic receive_frame(input string name);
		int base;
		int t;
		base = u_ram.rd_count;
		for (int i = 0; i < RXN; i++) begin
			rx_words[i] = WW'($urandom());
			u_ram.preload(AW'(BASE + i), rx_words[i]);
		end
		i_r_valid = 1'b1;
		@(negedge i_clk);
		i_r_valid = 1'b0;
		t = 0;
		while (!o_rx_done && t < LIMIT) begin
			@(negedge i_clk);
			t++;
		end
		if (!o_rx_done) begin
			report_timeout("o_rx_done");
		end else begin
			compare_value({name, " read count"}, PW'(RXN), PW'(u_ram.rd_count - base));
			for (int i = 0; i < RXN; i++) begin
				compare_value($sformatf("%s read %0d address", name, i), PW'(BASE + i),
					PW'(u_ram.rd_addr[(base + i) % 256]));
			end
			for (int f = 0; f < 7; f++) begin
				compare_value($sformatf("%s field %0d", name, f), rx_expected(f),
					rx_actual(f));
			end
		end
	endtask

	// checks each frame as o_w_valid rises
	initial begin : compare_tx
		int base;
		logic prev;
		base = 0;
		prev = 1'b0;
		forever begin
			@(negedge i_clk);
			if (o_w_valid && !prev) begin
				compare_value("tx write count", PW'(TXN), PW'(u_ram.wr_count - base));
				for (int i = 0; i < TXN; i++) begin
					compare_value($sformatf("tx slot %0d address", i), i,
						PW'(u_ram.tx_addr[(base + i) % 256]));
					compare_value($sformatf("tx slot %0d data", i), PW'(tx_expected_word(i)),
						PW'(u_ram.tx_data[(base + i) % 256]));
				end
				base = u_ram.wr_count;
				frames++;
			end
			prev = o_w_valid;
		end
	end

	// DSP side of the transmit handshake holds ready off for a while
	initial begin : ack_tx
		int t;
		int hold;
		int count;
		while (!timed_out) begin
			t = 0;
			while (!o_w_valid && t < LIMIT) begin
				@(negedge i_clk);
				t++;
			end
			if (!o_w_valid) begin
				report_timeout("o_w_valid to rise");
			end else begin
				hold = $urandom_range(40, 5);
				count = u_ram.wr_count;
				repeat (hold) begin
					@(negedge i_clk);
					compare_value("backpressure valid", 1, PW'(o_w_valid));
					compare_value("backpressure writes", count, u_ram.wr_count);
				end
				randomize_fields();
				i_w_ready = 1'b1;
				t = 0;
				while (o_w_valid && t < LIMIT) begin
					@(negedge i_clk);
					t++;
				end
				if (o_w_valid) report_timeout("o_w_valid to fall");
				i_w_ready = 1'b0;
			end
		end
	end

	initial begin : main_flow
		int t;
		void'($urandom(96));
		i_w_ready = 1'b0;
		i_r_valid = 1'b0;
		randomize_fields();
		for (int i = 0; i < RXN; i++) begin
			rx_words[i] = '0;
		end
		@(negedge i_clk);
		check_quiet("during reset");
		t = 0;
		while (!i_rst && t < LIMIT) begin
			@(posedge i_clk);
			t++;
		end
		if (!i_rst) begin
			report_timeout("reset release");
		end else begin
			@(negedge i_clk);
			check_quiet("after reset");
			idle_rx_window("rx wait", 100);
			receive_frame("rx frame 1");
		end
		if (!timed_out) begin
			idle_rx_window("rx hold", 100);
			receive_frame("rx frame 2");
		end
		if (!timed_out) begin
			t = 0;
			while (frames < 6 && t < LIMIT) begin
				@(negedge i_clk);
				t++;
			end
			if (frames < 6) report_timeout("six transmit frames");
		end
		end_run();
	end

endmodule

//--- testbench/tb_dsp_handler_assert.sv
`timescale 1ns/1ps

module tb_dsp_handler_assert (
	input logic                             i_clk,
	input logic                             i_rst,
	input logic                             o_w_valid,
	input logic                             o_xintf_w_ram_ce,
	input logic [dsp_xintf_pkg::ADDR_W-1:0] o_xintf_w_ram_addr,
	input logic                             o_xintf_r_ram_ce,
	input logic [dsp_xintf_pkg::ADDR_W-1:0] o_xintf_r_ram_addr,
	input logic                             o_rx_done
);

	localparam int AW = dsp_xintf_pkg::ADDR_W;
	localparam int R_END = dsp_xintf_pkg::RX_BASE + dsp_xintf_pkg::RX_WORDS - 1;
	localparam logic [AW-1:0] W_END = AW'(dsp_xintf_pkg::TX_WORDS);
	localparam logic [AW-1:0] R_FIRST = AW'(dsp_xintf_pkg::RX_BASE);
	localparam logic [AW-1:0] R_LAST = AW'(R_END);

	write_addr_in_frame: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_xintf_w_ram_ce |-> (o_xintf_w_ram_addr < W_END))
		else $error("write address %0d outside the transmit frame", o_xintf_w_ram_addr);

	read_addr_in_window: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_xintf_r_ram_ce |-> (o_xintf_r_ram_addr >= R_FIRST && o_xintf_r_ram_addr <= R_LAST))
		else $error("read address %0d outside the receive window", o_xintf_r_ram_addr);

	// frame must be complete before the DSP is told
	no_write_while_valid: assert property (@(posedge i_clk) disable iff (!i_rst)
		!(o_w_valid && o_xintf_w_ram_ce))
		else $error("ram write while o_w_valid is high");

	rx_done_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_rx_done |=> !o_rx_done)
		else $error("o_rx_done high for more than one cycle");

endmodule

//--- testbench/tb_dpbram_model.sv
`timescale 1ns/1ps

module tb_dpbram_model (
	input  logic                             i_clk,
	input  logic                             i_w_ce,
	input  logic [dsp_xintf_pkg::ADDR_W-1:0] i_w_addr,
	input  logic [dsp_xintf_pkg::WORD_W-1:0] i_w_din,
	input  logic                             i_r_ce,
	input  logic [dsp_xintf_pkg::ADDR_W-1:0] i_r_addr,
	output logic [dsp_xintf_pkg::WORD_W-1:0] o_r_dout
);

	localparam int AW = dsp_xintf_pkg::ADDR_W;
	localparam int WW = dsp_xintf_pkg::WORD_W;

	logic [WW-1:0] rx_mem [0:(1<<AW)-1];
	// write and read logs, in order of arrival
	logic [AW-1:0] tx_addr [0:255];
	logic [WW-1:0] tx_data [0:255];
	logic [AW-1:0] rd_addr [0:255];
	int wr_count = 0;
	int rd_count = 0;

	always @(posedge i_clk) begin
		if (i_w_ce) begin
			tx_addr[wr_count[7:0]] <= i_w_addr;
			tx_data[wr_count[7:0]] <= i_w_din;
			wr_count <= wr_count + 1;
		end
		if (i_r_ce) begin
			rd_addr[rd_count[7:0]] <= i_r_addr;
			rd_count <= rd_count + 1;
			o_r_dout <= rx_mem[i_r_addr];
		end
	end

	task automatic preload(input logic [AW-1:0] addr, input logic [WW-1:0] data);
		rx_mem[addr] = data;
	endtask

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// release on a falling edge, away from the DUT's sampling edge
	initial begin
		o_rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst = 1'b1;
	end

endmodule

//--- src/dsp_handler.sv
`timescale 1ns/1ps

module dsp_handler (
	input  logic                              i_clk,
	input  logic                              i_rst,

	// transmit handshake and ram write port
	input  logic                              i_w_ready,
	output logic                              o_w_valid,
	output logic                              o_xintf_w_ram_ce,
	output logic [dsp_xintf_pkg::ADDR_W-1:0]  o_xintf_w_ram_addr,
	output logic [dsp_xintf_pkg::WORD_W-1:0]  o_xintf_w_ram_din,

	// transmit fields
	input  logic [dsp_xintf_pkg::WORD_W-1:0]  i_set_mode,
	input  logic [dsp_xintf_pkg::WORD_W-1:0]  i_set_cmd,
	input  logic [dsp_xintf_pkg::PARAM_W-1:0] i_max_duty,
	input  logic [dsp_xintf_pkg::PARAM_W-1:0] i_max_phase,
	input  logic [dsp_xintf_pkg::PARAM_W-1:0] i_set_c,
	input  logic [dsp_xintf_pkg::PARAM_W-1:0] i_set_v,
	input  logic [dsp_xintf_pkg::PARAM_W-1:0] i_c_adc,
	input  logic [dsp_xintf_pkg::PARAM_W-1:0] i_v_adc,

	// receive start and ram read port
	input  logic                              i_r_valid,
	output logic                              o_xintf_r_ram_ce,
	output logic [dsp_xintf_pkg::ADDR_W-1:0]  o_xintf_r_ram_addr,
	input  logic [dsp_xintf_pkg::WORD_W-1:0]  i_xintf_r_ram_dout,

	// received parameters
	output logic [dsp_xintf_pkg::PARAM_W-1:0] o_dsp_max_duty,
	output logic [dsp_xintf_pkg::PARAM_W-1:0] o_dsp_max_phase,
	output logic [dsp_xintf_pkg::PARAM_W-1:0] o_dsp_set_c,
	output logic [dsp_xintf_pkg::PARAM_W-1:0] o_dsp_set_v,
	output logic [dsp_xintf_pkg::WORD_W-1:0]  o_dsp_status,
	output logic [dsp_xintf_pkg::WORD_W-1:0]  o_dsp_cmd,
	output logic [dsp_xintf_pkg::WORD_W-1:0]  o_dsp_ver,
	output logic                              o_rx_done
);

	logic tx_word_en;
	dsp_xintf_pkg::tx_slot_t tx_slot;
	logic rx_cap_en;
	dsp_xintf_pkg::rx_slot_t rx_slot;

	tx_sequencer #(
		.TX_WORDS (dsp_xintf_pkg::TX_WORDS)
	) u_tx_sequencer (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_w_ready (i_w_ready),
		.o_word_en (tx_word_en),
		.o_w_valid (o_w_valid),
		.o_slot    (tx_slot)
	);

	tx_word_select u_tx_word_select (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_word_en   (tx_word_en),
		.i_slot      (tx_slot),
		.i_set_mode  (i_set_mode),
		.i_set_cmd   (i_set_cmd),
		.i_max_duty  (i_max_duty),
		.i_max_phase (i_max_phase),
		.i_set_c     (i_set_c),
		.i_set_v     (i_set_v),
		.i_c_adc     (i_c_adc),
		.i_v_adc     (i_v_adc),
		.o_ram_ce    (o_xintf_w_ram_ce),
		.o_ram_addr  (o_xintf_w_ram_addr),
		.o_ram_din   (o_xintf_w_ram_din)
	);

	rx_sequencer #(
		.RX_BASE  (dsp_xintf_pkg::RX_BASE),
		.RX_WORDS (dsp_xintf_pkg::RX_WORDS)
	) u_rx_sequencer (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_r_valid  (i_r_valid),
		.o_ram_ce   (o_xintf_r_ram_ce),
		.o_ram_addr (o_xintf_r_ram_addr),
		.o_cap_en   (rx_cap_en),
		.o_slot     (rx_slot),
		.o_done     (o_rx_done)
	);

	rx_param_bank u_rx_param_bank (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_cap_en     (rx_cap_en),
		.i_slot       (rx_slot),
		.i_ram_dout   (i_xintf_r_ram_dout),
		.o_max_duty   (o_dsp_max_duty),
		.o_max_phase  (o_dsp_max_phase),
		.o_set_c      (o_dsp_set_c),
		.o_set_v      (o_dsp_set_v),
		.o_dsp_status (o_dsp_status),
		.o_dsp_cmd    (o_dsp_cmd),
		.o_dsp_ver    (o_dsp_ver)
	);

endmodule

//--- src/rx_param_bank.sv
`timescale 1ns/1ps

module rx_param_bank (
	input  logic                              i_clk,
	input  logic                              i_rst,
	input  logic                              i_cap_en,
	input  dsp_xintf_pkg::rx_slot_t           i_slot,
	input  logic [dsp_xintf_pkg::WORD_W-1:0]  i_ram_dout,
	output logic [dsp_xintf_pkg::PARAM_W-1:0] o_max_duty,
	output logic [dsp_xintf_pkg::PARAM_W-1:0] o_max_phase,
	output logic [dsp_xintf_pkg::PARAM_W-1:0] o_set_c,
	output logic [dsp_xintf_pkg::PARAM_W-1:0] o_set_v,
	output logic [dsp_xintf_pkg::WORD_W-1:0]  o_dsp_status,
	output logic [dsp_xintf_pkg::WORD_W-1:0]  o_dsp_cmd,
	output logic [dsp_xintf_pkg::WORD_W-1:0]  o_dsp_ver
);

	localparam int WW = dsp_xintf_pkg::WORD_W;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_max_duty <= '0;
			o_max_phase <= '0;
			o_set_c <= '0;
			o_set_v <= '0;
			o_dsp_status <= '0;
			o_dsp_cmd <= '0;
			o_dsp_ver <= '0;
		end else if (i_cap_en) begin
			// low half arrives first for the 32-bit values
			case (i_slot)
				dsp_xintf_pkg::RX_MAX_DUTY: begin
					o_max_duty[WW-1:0] <= i_ram_dout;
				end
				dsp_xintf_pkg::RX_MAX_DUTY + 1'b1: begin
					o_max_duty[2*WW-1:WW] <= i_ram_dout;
				end
				dsp_xintf_pkg::RX_MAX_PHASE: begin
					o_max_phase[WW-1:0] <= i_ram_dout;
				end
				dsp_xintf_pkg::RX_MAX_PHASE + 1'b1: begin
					o_max_phase[2*WW-1:WW] <= i_ram_dout;
				end
				dsp_xintf_pkg::RX_SET_C: begin
					o_set_c[WW-1:0] <= i_ram_dout;
				end
				dsp_xintf_pkg::RX_SET_C + 1'b1: begin
					o_set_c[2*WW-1:WW] <= i_ram_dout;
				end
				dsp_xintf_pkg::RX_SET_V: begin
					o_set_v[WW-1:0] <= i_ram_dout;
				end
				dsp_xintf_pkg::RX_SET_V + 1'b1: begin
					o_set_v[2*WW-1:WW] <= i_ram_dout;
				end
				dsp_xintf_pkg::RX_STATUS: begin
					o_dsp_status <= i_ram_dout;
				end
				dsp_xintf_pkg::RX_CMD: begin
					o_dsp_cmd <= i_ram_dout;
				end
				dsp_xintf_pkg::RX_VER: begin
					o_dsp_ver <= i_ram_dout;
				end
				default: begin
					// slot outside the map, nothing to store
				end
			endcase
		end
	end

endmodule

//--- src/rx_sequencer.sv
`timescale 1ns/1ps

module rx_sequencer #(
	parameter int RX_BASE = 128,
	parameter int RX_WORDS = 11
) (
	input  logic                             i_clk,
	input  logic                             i_rst,
	input  logic                             i_r_valid,
	output logic                             o_ram_ce,
	output logic [dsp_xintf_pkg::ADDR_W-1:0] o_ram_addr,
	output logic                             o_cap_en,
	output dsp_xintf_pkg::rx_slot_t          o_slot,
	output logic                             o_done
);

	localparam int AW = dsp_xintf_pkg::ADDR_W;
	localparam int LAST_IDX = RX_WORDS - 1;
	localparam logic [AW-1:0] BASE_ADDR = RX_BASE[AW-1:0];
	localparam dsp_xintf_pkg::rx_slot_t LAST_SLOT =
		LAST_IDX[$bits(dsp_xintf_pkg::rx_slot_t)-1:0];

	typedef enum logic [1:0] {
		S_WAIT,
		S_READ,
		S_DONE
	} state_t;

	state_t state;
	dsp_xintf_pkg::rx_slot_t rd_slot;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state <= S_WAIT;
			rd_slot <= '0;
			o_ram_ce <= 1'b0;
			o_ram_addr <= '0;
			o_cap_en <= 1'b0;
			o_slot <= '0;
			o_done <= 1'b0;
		end else begin
			// ram data returns one cycle after its address
			o_cap_en <= o_ram_ce;
			o_slot <= rd_slot;
			// last capture happens in S_DONE
			o_done <= (state == S_DONE);
			case (state)
				S_WAIT: begin
					if (i_r_valid) begin
						rd_slot <= '0;
						o_ram_ce <= 1'b1;
						o_ram_addr <= BASE_ADDR;
						state <= S_READ;
					end
				end
				S_READ: begin
					if (rd_slot == LAST_SLOT) begin
						o_ram_ce <= 1'b0;
						o_ram_addr <= '0;
						state <= S_DONE;
					end else begin
						rd_slot <= rd_slot + 1'b1;
						o_ram_addr <= o_ram_addr + 1'b1;
					end
				end
				S_DONE: begin
					state <= S_WAIT;
				end
				default: begin
					state <= S_WAIT;
				end
			endcase
		end
	end

endmodule

//--- src/tx_word_select.sv
`timescale 1ns/1ps

module tx_word_select (
	input  logic                                i_clk,
	input  logic                                i_rst,
	input  logic                                i_word_en,
	input  dsp_xintf_pkg::tx_slot_t             i_slot,
	input  logic [dsp_xintf_pkg::WORD_W-1:0]    i_set_mode,
	input  logic [dsp_xintf_pkg::WORD_W-1:0]    i_set_cmd,
	input  logic [dsp_xintf_pkg::PARAM_W-1:0]   i_max_duty,
	input  logic [dsp_xintf_pkg::PARAM_W-1:0]   i_max_phase,
	input  logic [dsp_xintf_pkg::PARAM_W-1:0]   i_set_c,
	input  logic [dsp_xintf_pkg::PARAM_W-1:0]   i_set_v,
	input  logic [dsp_xintf_pkg::PARAM_W-1:0]   i_c_adc,
	input  logic [dsp_xintf_pkg::PARAM_W-1:0]   i_v_adc,
	output logic                                o_ram_ce,
	output logic [dsp_xintf_pkg::ADDR_W-1:0]    o_ram_addr,
	output logic [dsp_xintf_pkg::WORD_W-1:0]    o_ram_din
);

	localparam int WW = dsp_xintf_pkg::WORD_W;
	localparam int PAD_W = dsp_xintf_pkg::ADDR_W - $bits(dsp_xintf_pkg::tx_slot_t);

	logic [WW-1:0] word;

	always_comb begin
		case (i_slot)
			dsp_xintf_pkg::TX_MODE:             word = i_set_mode;
			dsp_xintf_pkg::TX_CMD:              word = i_set_cmd;
			dsp_xintf_pkg::TX_MAX_DUTY:         word = i_max_duty[WW-1:0];
			dsp_xintf_pkg::TX_MAX_DUTY + 1'b1:  word = i_max_duty[2*WW-1:WW];
			dsp_xintf_pkg::TX_MAX_PHASE:        word = i_max_phase[WW-1:0];
			dsp_xintf_pkg::TX_MAX_PHASE + 1'b1: word = i_max_phase[2*WW-1:WW];
			dsp_xintf_pkg::TX_SET_C:            word = i_set_c[WW-1:0];
			dsp_xintf_pkg::TX_SET_C + 1'b1:     word = i_set_c[2*WW-1:WW];
			dsp_xintf_pkg::TX_SET_V:            word = i_set_v[WW-1:0];
			dsp_xintf_pkg::TX_SET_V + 1'b1:     word = i_set_v[2*WW-1:WW];
			dsp_xintf_pkg::TX_C_ADC:            word = i_c_adc[WW-1:0];
			dsp_xintf_pkg::TX_C_ADC + 1'b1:     word = i_c_adc[2*WW-1:WW];
			dsp_xintf_pkg::TX_V_ADC:            word = i_v_adc[WW-1:0];
			dsp_xintf_pkg::TX_V_ADC + 1'b1:     word = i_v_adc[2*WW-1:WW];
			default:                            word = '0;
		endcase
	end

	// address equals the slot, back to zero between words
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_ram_ce <= 1'b0;
			o_ram_addr <= '0;
		end else if (i_word_en) begin
			o_ram_ce <= 1'b1;
			o_ram_addr <= {{PAD_W{1'b0}}, i_slot};
		end else begin
			o_ram_ce <= 1'b0;
			o_ram_addr <= '0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_word_en) begin
			o_ram_din <= word;
		end
	end

endmodule

//--- src/tx_sequencer.sv
`timescale 1ns/1ps

module tx_sequencer #(
	parameter int TX_WORDS = 14
) (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_w_ready,
	output logic                    o_word_en,
	output logic                    o_w_valid,
	output dsp_xintf_pkg::tx_slot_t o_slot
);

	localparam int LAST_IDX = TX_WORDS - 1;
	localparam dsp_xintf_pkg::tx_slot_t LAST_SLOT =
		LAST_IDX[$bits(dsp_xintf_pkg::tx_slot_t)-1:0];

	typedef enum logic [2:0] {
		S_IDLE,
		S_SETUP,
		S_WRITE,
		S_WAIT,
		S_DONE
	} state_t;

	state_t state;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state <= S_IDLE;
			o_slot <= '0;
			o_w_valid <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					state <= S_SETUP;
				end
				S_SETUP: begin
					o_slot <= '0;
					state <= S_WRITE;
				end
				S_WRITE: begin
					if (o_slot == LAST_SLOT) begin
						o_slot <= '0;
						state <= S_WAIT;
					end else begin
						o_slot <= o_slot + 1'b1;
					end
				end
				// valid comes up one cycle late so the last ram write lands first
				S_WAIT: begin
					if (o_w_valid && i_w_ready) begin
						o_w_valid <= 1'b0;
						state <= S_DONE;
					end else begin
						o_w_valid <= 1'b1;
					end
				end
				S_DONE: begin
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// one word per cycle while writing
	assign o_word_en = (state == S_WRITE);

endmodule

//--- src/dsp_xintf_pkg.sv
package dsp_xintf_pkg;

	// ram word and parameter widths
	localparam int WORD_W = 16;
	localparam int PARAM_W = 32;
	localparam int ADDR_W = 9;

	// frame sizes
	localparam int TX_WORDS = 14;
	localparam int RX_WORDS = 11;

	// receive window starts here
	localparam int RX_BASE = 128;

	typedef logic [3:0] tx_slot_t;
	typedef logic [3:0] rx_slot_t;

	// transmit slots, 32-bit fields take low then high
	localparam tx_slot_t TX_MODE = 4'd0;
	localparam tx_slot_t TX_CMD = 4'd1;
	localparam tx_slot_t TX_MAX_DUTY = 4'd2;
	localparam tx_slot_t TX_MAX_PHASE = 4'd4;
	localparam tx_slot_t TX_SET_C = 4'd6;
	localparam tx_slot_t TX_SET_V = 4'd8;
	localparam tx_slot_t TX_C_ADC = 4'd10;
	localparam tx_slot_t TX_V_ADC = 4'd12;

	// receive slots, offsets from RX_BASE
	localparam rx_slot_t RX_MAX_DUTY = 4'd0;
	localparam rx_slot_t RX_MAX_PHASE = 4'd2;
	localparam rx_slot_t RX_SET_C = 4'd4;
	localparam rx_slot_t RX_SET_V = 4'd6;
	localparam rx_slot_t RX_STATUS = 4'd8;
	localparam rx_slot_t RX_CMD = 4'd9;
	localparam rx_slot_t RX_VER = 4'd10;

endpackage
